// File: filelist.f
+incdir+src
src/cachePkg.sv
src/cacheArrayIf.sv
src/cacheTagArray.sv
src/cacheDataArray.sv
src/cacheCtrlRegs.sv
src/cacheController.sv
src/cacheTop.sv
test/cacheTb.sv

// File: src/cacheArrayIf.sv
`timescale 1ns/1ns
`default_nettype none

interface cacheArrayIf;

  // driven by controller
  cachePkg::indexT   index;
  logic              rdEn;
  cachePkg::wayMaskT wrWay;
  cachePkg::tagT     wrTag;
  cachePkg::lineT    wrLine;

  // tag array read results
  cachePkg::tagT     rdTag0;
  cachePkg::tagT     rdTag1;
  logic              rdValid0;
  logic              rdValid1;

  // data array read results
  cachePkg::lineT    rdLine0;
  cachePkg::lineT    rdLine1;

  modport ctrl (
    output index, rdEn, wrWay, wrTag, wrLine,
    input  rdTag0, rdTag1, rdValid0, rdValid1,
    input  rdLine0, rdLine1
  );

  modport tags (
    input  index, rdEn, wrWay, wrTag,
    output rdTag0, rdTag1, rdValid0, rdValid1
  );

  modport lines (
    input  index, rdEn, wrWay, wrLine,
    output rdLine0, rdLine1
  );

endinterface

`default_nettype wire

// File: src/cacheController.sv
`include "cache_settings.svh"
`timescale 1ns/1ns
`default_nettype none

module cacheController (
  input  wire logic           clk,
  input  wire logic           rst_n,
  // core side
  input  wire logic           reqValid_i,
  input  wire cachePkg::addrT reqAddr_i,
  output logic                addrOk_o,
  output logic                dataOk_o,
  output cachePkg::wordT      rdData_o,
  // memory side
  output logic                memReqValid_o,
  input  wire logic           memReqReady_i,
  output cachePkg::addrT      memAddr_o,
  input  wire logic           memRdValid_i,
  input  wire logic           memRdLast_i,
  input  wire cachePkg::wordT memRdData_i,
  // tag and data arrays
  cacheArrayIf.ctrl           arr,
  // register block
  input  wire logic           cacheEnable_i,
  output logic                ctrlIdle_o,
  output logic                hitEvent_o,
  output logic                missEvent_o
);

  // address split: tag | index | offset
  localparam int idxLo    = `CACHE_OFFSET_W;
  localparam int tagLo    = `CACHE_OFFSET_W + `CACHE_INDEX_W;
  // doubleword select and beat count share a width
  localparam int wordSelW = $clog2(`CACHE_BEATS);

  cachePkg::ctrlStateT   state;
  cachePkg::ctrlStateT   nextState;

  cachePkg::addrT        reqAddr;
  cachePkg::tagT         reqTag;
  cachePkg::indexT       reqIndex;
  logic [wordSelW-1:0]   reqWord;

  logic                  hit0;
  logic                  hit1;
  logic                  lookupHit;
  logic                  inCompare;
  logic                  inInstall;
  logic                  accept;

  cachePkg::lineT        fillBuf;
  logic [wordSelW-1:0]   beatCnt;
  cachePkg::lineT        outLine;

  logic [7:0]            lfsr;
  logic                  lfsrFb;
  cachePkg::wayMaskT     victim;

  // latched request fields
  assign reqTag   = reqAddr[`CACHE_ADDR_W-1:tagLo];
  assign reqIndex = reqAddr[tagLo-1:idxLo];
  assign reqWord  = reqAddr[`CACHE_OFFSET_W-1 -: wordSelW];

  assign inCompare = (state == cachePkg::COMPARE);
  assign inInstall = (state == cachePkg::INSTALL);

  // tag compare against held array outputs
  assign hit0 = arr.rdValid0 && (arr.rdTag0 == reqTag);
  assign hit1 = arr.rdValid1 && (arr.rdTag1 == reqTag);
  // disabled cache never hits, every lookup refills
  assign lookupHit = cacheEnable_i && (hit0 || hit1);

  // core handshake
  assign addrOk_o = (state == cachePkg::IDLE) || (inCompare && lookupHit);
  assign accept   = reqValid_i && addrOk_o;
  assign dataOk_o = (inCompare && lookupHit) || inInstall;

  // data from hit way, or from refill buffer on the install cycle
  assign outLine  = inInstall ? fillBuf : (hit1 ? arr.rdLine1 : arr.rdLine0);
  assign rdData_o = outLine[reqWord*`CACHE_XLEN +: `CACHE_XLEN];

  // status toward regs, one pulse per lookup
  assign ctrlIdle_o  = (state == cachePkg::IDLE);
  assign hitEvent_o  = inCompare && lookupHit;
  assign missEvent_o = inCompare && !lookupHit;

  // line request, held in MISS until ready
  assign memReqValid_o = (state == cachePkg::MISS);
  assign memAddr_o     = {reqAddr[`CACHE_ADDR_W-1:idxLo], {`CACHE_OFFSET_W{1'b0}}};

  // array port
  // new lookups read at the incoming index, install writes the latched one
  assign arr.rdEn   = accept;
  assign arr.index  = accept ? reqAddr_i[tagLo-1:idxLo] : reqIndex;
  assign arr.wrTag  = reqTag;
  assign arr.wrLine = fillBuf;
  assign arr.wrWay  = (inInstall && cacheEnable_i) ? victim : '0;

  // victim: first invalid way, else lfsr pick
  // valid bits still hold the lookup of this set
  always_comb begin
    if (!arr.rdValid0) begin
      victim = 2'b01;
    end else if (!arr.rdValid1) begin
      victim = 2'b10;
    end else begin
      victim = lfsr[0] ? 2'b10 : 2'b01;
    end
  end

  // x^8 + x^6 + x^5 + x^4 + 1, free running
  assign lfsrFb = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lfsr <= `CACHE_LFSR_SEED;
    end else begin
      lfsr <= {lfsr[6:0], lfsrFb};
    end
  end

  // next state
  always_comb begin
    nextState = state;
    case (state)
      cachePkg::IDLE: begin
        if (accept) begin
          nextState = cachePkg::COMPARE;
        end
      end
      cachePkg::COMPARE: begin
        // a hit can take the next request straight away
        if (!lookupHit) begin
          nextState = cachePkg::MISS;
        end else if (!reqValid_i) begin
          nextState = cachePkg::IDLE;
        end
      end
      cachePkg::MISS: begin
        if (memReqReady_i) begin
          nextState = cachePkg::FILL;
        end
      end
      cachePkg::FILL: begin
        if (memRdValid_i && memRdLast_i) begin
          nextState = cachePkg::INSTALL;
        end
      end
      cachePkg::INSTALL: begin
        nextState = cachePkg::IDLE;
      end
      default: begin
        nextState = cachePkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= cachePkg::IDLE;
    end else begin
      state <= nextState;
    end
  end

  // request latch
  always_ff @(posedge clk) begin
    if (accept) begin
      reqAddr <= reqAddr_i;
    end
  end

  // beat counter, rearmed while waiting on the request
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (state == cachePkg::MISS) begin
      beatCnt <= '0;
    end else if ((state == cachePkg::FILL) && memRdValid_i) begin
      beatCnt <= beatCnt + 1'b1;
    end
  end

  // refill buffer, lowest doubleword arrives first
  always_ff @(posedge clk) begin
    if ((state == cachePkg::FILL) && memRdValid_i) begin
      fillBuf[beatCnt*`CACHE_XLEN +: `CACHE_XLEN] <= memRdData_i;
    end
  end

  // install never touches both ways
  assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(arr.wrWay));

  // request and address held until memory takes them
  assert property (@(posedge clk) disable iff (!rst_n)
    memReqValid_o && !memReqReady_i |=> memReqValid_o && $stable(memAddr_o));

endmodule

`default_nettype wire

// File: src/cacheCtrlRegs.sv
`timescale 1ns/1ns
`default_nettype none

module cacheCtrlRegs (
  input  wire logic              clk,
  input  wire logic              rst_n,
  // config port
  input  wire logic              cfgWrite_i,
  input  wire cachePkg::cfgAddrT cfgAddr_i,
  input  wire cachePkg::cfgDataT cfgWdata_i,
  output cachePkg::cfgDataT      cfgRdata_o,
  // controller status
  input  wire logic              ctrlIdle_i,
  input  wire logic              hitEvent_i,
  input  wire logic              missEvent_i,
  // controls
  output logic                   cacheEnable_o,
  output logic                   flushStrobe_o
);

  // register map
  localparam cachePkg::cfgAddrT ctrlAddr = 2'd0;
  localparam cachePkg::cfgAddrT hitAddr  = 2'd1;
  localparam cachePkg::cfgAddrT missAddr = 2'd2;

  logic              flushPend;
  logic              wrCtrl;
  logic              wrHit;
  logic              wrMiss;
  cachePkg::cfgDataT hitCnt;
  cachePkg::cfgDataT missCnt;

  // clear on write, else count up and stick at all ones
  function automatic cachePkg::cfgDataT bumpCount(input cachePkg::cfgDataT cnt,
                                                  input logic clr, input logic inc);
    if (clr) begin
      return '0;
    end
    if (inc && (cnt != '1)) begin
      return cnt + 1'b1;
    end
    return cnt;
  endfunction

  assign wrCtrl = cfgWrite_i && (cfgAddr_i == ctrlAddr);
  assign wrHit  = cfgWrite_i && (cfgAddr_i == hitAddr);
  assign wrMiss = cfgWrite_i && (cfgAddr_i == missAddr);

  // flush fires in the first idle cycle after the request
  assign flushStrobe_o = flushPend && ctrlIdle_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cacheEnable_o <= 1'b1;
      flushPend     <= 1'b0;
      hitCnt        <= '0;
      missCnt       <= '0;
    end else begin
      if (wrCtrl) begin
        cacheEnable_o <= cfgWdata_i[0];
      end
      // a write landing on the strobe cycle is covered by that flush
      if (flushStrobe_o) begin
        flushPend <= 1'b0;
      end else if (wrCtrl && cfgWdata_i[1]) begin
        flushPend <= 1'b1;
      end
      hitCnt  <= bumpCount(hitCnt, wrHit, hitEvent_i);
      missCnt <= bumpCount(missCnt, wrMiss, missEvent_i);
    end
  end

  // readback, flush bit reads as pending
  always_comb begin
    case (cfgAddr_i)
      ctrlAddr: cfgRdata_o = {30'd0, flushPend, cacheEnable_o};
      hitAddr:  cfgRdata_o = hitCnt;
      missAddr: cfgRdata_o = missCnt;
      default:  cfgRdata_o = '0;
    endcase
  end

  // strobe is a single idle cycle
  assert property (@(posedge clk) disable iff (!rst_n)
    flushStrobe_o |-> ctrlIdle_i ##1 !flushStrobe_o);

endmodule

`default_nettype wire

// File: src/cacheDataArray.sv
`include "cache_settings.svh"
`timescale 1ns/1ns
`default_nettype none

module cacheDataArray (
  input  wire logic  clk,
  cacheArrayIf.lines arr
);

  // behavioral line sram, one per way
  // contents undefined until first install
  cachePkg::lineT lineMem [`CACHE_WAYS][`CACHE_SETS];

  // whole line write, selected way only
  always_ff @(posedge clk) begin
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (arr.wrWay[w]) begin
        lineMem[w][arr.index] <= arr.wrLine;
      end
    end
  end

  // synchronous read of both ways
  // output holds between reads like the sram Q pins
  always_ff @(posedge clk) begin
    if (arr.rdEn) begin
      arr.rdLine0 <= lineMem[0][arr.index];
      arr.rdLine1 <= lineMem[1][arr.index];
    end
  end

endmodule

`default_nettype wire

// File: src/cachePkg.sv
`include "cache_settings.svh"
`default_nettype none

package cachePkg;

  // core request address
  typedef logic [`CACHE_ADDR_W-1:0]  addrT;
  // one doubleword, core and memory beat width
  typedef logic [`CACHE_XLEN-1:0]    wordT;
  // full cache line
  typedef logic [`CACHE_LINE_W-1:0]  lineT;
  // set number
  typedef logic [`CACHE_INDEX_W-1:0] indexT;
  // address tag
  typedef logic [`CACHE_TAG_W-1:0]   tagT;
  // one-hot way select, zero = none
  typedef logic [`CACHE_WAYS-1:0]    wayMaskT;

  // config port
  typedef logic [1:0]                cfgAddrT;
  typedef logic [31:0]               cfgDataT;

  // request fsm
  typedef enum logic [2:0] {
    IDLE,
    COMPARE,
    MISS,
    FILL,
    INSTALL
  } ctrlStateT;

endpackage

`default_nettype wire

// File: src/cacheTagArray.sv
`include "cache_settings.svh"
`timescale 1ns/1ns
`default_nettype none

module cacheTagArray (
  input  wire logic  clk,
  input  wire logic  rst_n,
  input  wire logic  flush_i,
  cacheArrayIf.tags  arr
);

  // tag storage, one memory per way
  cachePkg::tagT tagMem [`CACHE_WAYS][`CACHE_SETS];

  // valid bits kept in flops so reset and flush can clear them at once
  logic [`CACHE_WAYS-1:0][`CACHE_SETS-1:0] validBits;

  // valid update
  // flush wins, otherwise a write marks its way valid
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validBits <= '0;
    end else if (flush_i) begin
      validBits <= '0;
    end else begin
      for (int w = 0; w < `CACHE_WAYS; w++) begin
        if (arr.wrWay[w]) begin
          validBits[w][arr.index] <= 1'b1;
        end
      end
    end
  end

  // tag write into selected way
  always_ff @(posedge clk) begin
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (arr.wrWay[w]) begin
        tagMem[w][arr.index] <= arr.wrTag;
      end
    end
  end

  // registered tag read, held until next rdEn
  always_ff @(posedge clk) begin
    if (arr.rdEn) begin
      arr.rdTag0 <= tagMem[0][arr.index];
      arr.rdTag1 <= tagMem[1][arr.index];
    end
  end

  // registered valid read
  // a flush at the same edge as a lookup must not leave a stale hit behind
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      arr.rdValid0 <= 1'b0;
      arr.rdValid1 <= 1'b0;
    end else if (flush_i) begin
      arr.rdValid0 <= 1'b0;
      arr.rdValid1 <= 1'b0;
    end else if (arr.rdEn) begin
      arr.rdValid0 <= validBits[0][arr.index];
      arr.rdValid1 <= validBits[1][arr.index];
    end
  end

  // flush only comes while controller idle, install only outside idle
  assert property (@(posedge clk) disable iff (!rst_n)
    !(flush_i && (|arr.wrWay)));

endmodule

`default_nettype wire

// File: src/cacheTop.sv
`timescale 1ns/1ns
`default_nettype none

module cacheTop (
  input  wire logic              clk,
  input  wire logic              rst_n,
  // core request port
  input  wire logic              reqValid_i,
  input  wire cachePkg::addrT    reqAddr_i,
  output logic                   addrOk_o,
  output logic                   dataOk_o,
  output cachePkg::wordT         rdData_o,
  // line refill port
  output logic                   memReqValid_o,
  input  wire logic              memReqReady_i,
  output cachePkg::addrT         memAddr_o,
  input  wire logic              memRdValid_i,
  input  wire logic              memRdLast_i,
  input  wire cachePkg::wordT    memRdData_i,
  // register access
  input  wire logic              cfgWrite_i,
  input  wire cachePkg::cfgAddrT cfgAddr_i,
  input  wire cachePkg::cfgDataT cfgWdata_i,
  output cachePkg::cfgDataT      cfgRdata_o
);

  // regs <-> controller / tag array
  logic flushStrobe;
  logic cacheEnable;
  logic ctrlIdle;
  logic hitEvent;
  logic missEvent;

  // controller <-> tag and data arrays
  cacheArrayIf arrIf ();

  cacheController uCtrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .reqValid_i    (reqValid_i),
    .reqAddr_i     (reqAddr_i),
    .addrOk_o      (addrOk_o),
    .dataOk_o      (dataOk_o),
    .rdData_o      (rdData_o),
    .memReqValid_o (memReqValid_o),
    .memReqReady_i (memReqReady_i),
    .memAddr_o     (memAddr_o),
    .memRdValid_i  (memRdValid_i),
    .memRdLast_i   (memRdLast_i),
    .memRdData_i   (memRdData_i),
    .arr           (arrIf.ctrl),
    .cacheEnable_i (cacheEnable),
    .ctrlIdle_o    (ctrlIdle),
    .hitEvent_o    (hitEvent),
    .missEvent_o   (missEvent)
  );

  cacheTagArray uTags (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (flushStrobe),
    .arr     (arrIf.tags)
  );

  cacheDataArray uLines (
    .clk (clk),
    .arr (arrIf.lines)
  );

  cacheCtrlRegs uRegs (
    .clk           (clk),
    .rst_n         (rst_n),
    .cfgWrite_i    (cfgWrite_i),
    .cfgAddr_i     (cfgAddr_i),
    .cfgWdata_i    (cfgWdata_i),
    .cfgRdata_o    (cfgRdata_o),
    .ctrlIdle_i    (ctrlIdle),
    .hitEvent_i    (hitEvent),
    .missEvent_i   (missEvent),
    .cacheEnable_o (cacheEnable),
    .flushStrobe_o (flushStrobe)
  );

endmodule

`default_nettype wire

// File: src/cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// request address and core data width
`define CACHE_ADDR_W     32
`define CACHE_XLEN       64

// line geometry, four doublewords per line
`define CACHE_LINE_W     256
`define CACHE_BEATS      4

// set and address split: tag | index | offset
`define CACHE_SETS       64
`define CACHE_INDEX_W    6
`define CACHE_OFFSET_W   5
`define CACHE_TAG_W      21

// associativity
`define CACHE_WAYS       2

// replacement lfsr start value, must be nonzero
`define CACHE_LFSR_SEED  8'hA5

`endif

// File: test/cacheTb.sv
`include "cache_settings.svh"
`timescale 1ns/1ns
`default_nettype none

module cacheTb;

  // line addresses used by the tests
  // A, B and C share index 2
  // E sits in set 8
  localparam cachePkg::addrT lineA = 32'h0000_1040;
  localparam cachePkg::addrT lineB = 32'h0000_1840;
  localparam cachePkg::addrT lineC = 32'h0000_2040;
  localparam cachePkg::addrT lineE = 32'h0000_3100;
  // F and G share set 0
  // H is in set 35
  localparam cachePkg::addrT lineF = 32'h0000_5000;
  localparam cachePkg::addrT lineG = 32'h0000_5800;
  localparam cachePkg::addrT lineH = 32'h0000_5460;

  logic                clk;
  logic                rst_n;
  logic                reqValid_i;
  cachePkg::addrT      reqAddr_i;
  logic                addrOk_o;
  logic                dataOk_o;
  cachePkg::wordT      rdData_o;
  logic                memReqValid_o;
  logic                memReqReady_i;
  cachePkg::addrT      memAddr_o;
  logic                memRdValid_i;
  logic                memRdLast_i;
  cachePkg::wordT      memRdData_i;
  logic                cfgWrite_i;
  cachePkg::cfgAddrT   cfgAddr_i;
  cachePkg::cfgDataT   cfgWdata_i;
  cachePkg::cfgDataT   cfgRdata_o;

  // memory model state
  cachePkg::cfgDataT   lineReqs;
  cachePkg::addrT      lastReqAddr;
  int unsigned         epoch;
  int unsigned         lcgState;
  // lines predicted resident for the counter test
  cachePkg::addrT      resident[$];

  cacheTop uut (
    .clk           (clk),
    .rst_n         (rst_n),
    .reqValid_i    (reqValid_i),
    .reqAddr_i     (reqAddr_i),
    .addrOk_o      (addrOk_o),
    .dataOk_o      (dataOk_o),
    .rdData_o      (rdData_o),
    .memReqValid_o (memReqValid_o),
    .memReqReady_i (memReqReady_i),
    .memAddr_o     (memAddr_o),
    .memRdValid_i  (memRdValid_i),
    .memRdLast_i   (memRdLast_i),
    .memRdData_i   (memRdData_i),
    .cfgWrite_i    (cfgWrite_i),
    .cfgAddr_i     (cfgAddr_i),
    .cfgWdata_i    (cfgWdata_i),
    .cfgRdata_o    (cfgRdata_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic int unsigned nextRand();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState >> 16;
  endfunction

  // doubleword at address a
  // offset bits below 8 bytes are ignored
  function automatic cachePkg::wordT memWord(input cachePkg::addrT a);
    cachePkg::addrT dw;
    dw = {a[31:3], 3'b000};
    return {cachePkg::addrT'(dw ^ (epoch * 32'h9E37_79B9)), cachePkg::addrT'(~dw + epoch)};
  endfunction

  function automatic cachePkg::addrT lineOf(input cachePkg::addrT a);
    return {a[31:`CACHE_OFFSET_W], {`CACHE_OFFSET_W{1'b0}}};
  endfunction

  function automatic bit isResident(input cachePkg::addrT line);
    foreach (resident[i]) begin
      if (resident[i] == line) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic checkWord(input string name, input cachePkg::wordT got,
                           input cachePkg::wordT exp);
    if (got !== exp) begin
      abortRun($sformatf("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic checkAddr(input string name, input cachePkg::addrT got,
                           input cachePkg::addrT exp);
    if (got !== exp) begin
      abortRun($sformatf("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic checkCount(input string name, input cachePkg::cfgDataT got,
                            input cachePkg::cfgDataT exp);
    if (got !== exp) begin
      abortRun($sformatf("ERROR at %0t ns: %s is %0d, expected %0d", $time, name, got, exp));
    end
  endtask

  // memory model answers after 0..3 cycles
  // four beats follow with 0..1 cycle gaps
  initial begin : memModel
    cachePkg::addrT lineAddr;
    int unsigned    waitCycles;
    forever begin
      @(negedge clk);
      if (rst_n && memReqValid_o) begin
        lineAddr    = memAddr_o;
        lastReqAddr = memAddr_o;
        lineReqs    = lineReqs + 1;
        waitCycles  = nextRand() % 4;
        repeat (waitCycles) @(negedge clk);
        memReqReady_i = 1'b1;
        @(negedge clk);
        memReqReady_i = 1'b0;
        for (int b = 0; b < `CACHE_BEATS; b++) begin
          waitCycles = nextRand() % 2;
          repeat (waitCycles) @(negedge clk);
          memRdValid_i = 1'b1;
          memRdLast_i  = (b == `CACHE_BEATS - 1);
          memRdData_i  = memWord(lineAddr + cachePkg::addrT'(b * 8));
          @(negedge clk);
          memRdValid_i = 1'b0;
          memRdLast_i  = 1'b0;
        end
      end
    end
  end

  // returns in the cycle where addrOk_o is high
  // the request is taken at the next rising edge
  task automatic waitAccepted();
    int n;
    n = 0;
    while (!addrOk_o) begin
      @(negedge clk);
      n++;
      if (n > 50) begin
        abortRun("the cache never accepted the request");
      end
    end
  endtask

  task automatic readOnce(input cachePkg::addrT a, output cachePkg::wordT data);
    int n;
    reqValid_i = 1'b1;
    reqAddr_i  = a;
    waitAccepted();
    @(negedge clk);
    reqValid_i = 1'b0;
    n = 0;
    while (!dataOk_o) begin
      @(negedge clk);
      n++;
      if (n > 100) begin
        abortRun("no data came back for an accepted read");
      end
    end
    data = rdData_o;
    @(negedge clk);
  endtask

  task automatic readCheck(input cachePkg::addrT a);
    cachePkg::wordT d;
    readOnce(a, d);
    checkWord("rdData_o", d, memWord(a));
  endtask

  task automatic writeReg(input cachePkg::cfgAddrT a, input cachePkg::cfgDataT d);
    cfgWrite_i = 1'b1;
    cfgAddr_i  = a;
    cfgWdata_i = d;
    @(negedge clk);
    cfgWrite_i = 1'b0;
  endtask

  task automatic readReg(input cachePkg::cfgAddrT a, output cachePkg::cfgDataT d);
    cfgAddr_i = a;
    @(negedge clk);
    d = cfgRdata_o;
  endtask

  // enable plus flush then poll until the pending bit drops
  task automatic flushCache();
    cachePkg::cfgDataT v;
    int                n;
    writeReg(2'd0, 32'h3);
    n = 0;
    v = 32'h2;
    while (v[1]) begin
      readReg(2'd0, v);
      n++;
      if (n > 20) begin
        abortRun("the flush request never completed");
      end
    end
  endtask

  task automatic coldMiss();
    cachePkg::cfgDataT reqs0;
    cachePkg::cfgDataT v;
    reqs0 = lineReqs;
    // first read is the top doubleword of the line
    for (int k = 0; k < 4; k++) begin
      readCheck(lineA + (3 - k) * 8);
    end
    checkCount("line requests", lineReqs - reqs0, 1);
    checkAddr("memAddr_o", lastReqAddr, lineOf(lineA));
    readReg(2'd2, v);
    checkCount("MISSCNT", v, 1);
    readReg(2'd1, v);
    checkCount("HITCNT", v, 3);
  endtask

  // one hit per cycle with odd low address bits
  task automatic backToBackHits();
    cachePkg::addrT    seq[$];
    cachePkg::cfgDataT reqs0;
    seq = '{lineA + 24, lineA, lineA + 8, lineA + 13, lineA + 16, lineA + 5, lineA + 31};
    reqs0 = lineReqs;
    reqValid_i = 1'b1;
    reqAddr_i  = seq[0];
    waitAccepted();
    foreach (seq[i]) begin
      @(negedge clk);
      if (!dataOk_o) begin
        abortRun($sformatf("hit %0d did not answer in the following cycle", i));
      end
      checkWord("rdData_o", rdData_o, memWord(seq[i]));
      if (i + 1 < seq.size()) begin
        if (!addrOk_o) begin
          abortRun("a back-to-back hit request was not accepted");
        end
        reqAddr_i = seq[i + 1];
      end else begin
        reqValid_i = 1'b0;
      end
    end
    @(negedge clk);
    checkCount("line requests", lineReqs - reqs0, 0);
  endtask

  task automatic twoWays();
    cachePkg::cfgDataT reqs0;
    reqs0 = lineReqs;
    readCheck(lineB);
    checkCount("line requests", lineReqs - reqs0, 1);
    readCheck(lineA + 16);
    readCheck(lineB + 8);
    checkCount("line requests", lineReqs - reqs0, 1);
    // third tag in a full set evicts one of the two
    readCheck(lineC + 24);
    checkCount("line requests", lineReqs - reqs0, 2);
  endtask

  // new epoch makes a stale hit show up as wrong data
  task automatic flushRefetch();
    cachePkg::cfgDataT reqs0;
    epoch = 2;
    flushCache();
    reqs0 = lineReqs;
    readCheck(lineC + 8);
    checkCount("line requests", lineReqs - reqs0, 1);
    readCheck(lineA);
    checkCount("line requests", lineReqs - reqs0, 2);
  endtask

  task automatic disabledReads();
    cachePkg::cfgDataT reqs0;
    epoch = 3;
    writeReg(2'd0, 32'h0);
    reqs0 = lineReqs;
    // line A is still valid but must not hit
    readCheck(lineA);
    checkCount("line requests", lineReqs - reqs0, 1);
    epoch = 4;
    readCheck(lineA);
    checkCount("line requests", lineReqs - reqs0, 2);
    writeReg(2'd0, 32'h1);
    readCheck(lineE + 8);
    checkCount("line requests", lineReqs - reqs0, 3);
    readCheck(lineE + 16);
    checkCount("line requests", lineReqs - reqs0, 3);
  endtask

  task automatic counterReadback();
    cachePkg::addrT    script[$];
    cachePkg::cfgDataT v;
    cachePkg::cfgDataT expHits;
    cachePkg::cfgDataT expMisses;
    // at most two lines per set so every miss finds an invalid way
    script = '{lineF, lineF + 8, lineG, lineF + 16, lineH, lineG + 24, lineH + 8, lineF + 31};
    flushCache();
    resident.delete();
    writeReg(2'd1, 32'hFFFF_FFFF);
    writeReg(2'd2, 32'h0000_0005);
    readReg(2'd1, v);
    checkCount("HITCNT", v, 0);
    readReg(2'd2, v);
    checkCount("MISSCNT", v, 0);
    expHits   = 0;
    expMisses = 0;
    foreach (script[i]) begin
      if (isResident(lineOf(script[i]))) begin
        expHits++;
      end else begin
        expMisses++;
        resident.push_back(lineOf(script[i]));
      end
      readCheck(script[i]);
    end
    readReg(2'd1, v);
    checkCount("HITCNT", v, expHits);
    readReg(2'd2, v);
    checkCount("MISSCNT", v, expMisses);
    readReg(2'd0, v);
    checkCount("CTRL", v, 1);
    readReg(2'd3, v);
    checkCount("unmapped register", v, 0);
  endtask

  initial begin : mainSeq
    rst_n         = 1'b0;
    reqValid_i    = 1'b0;
    reqAddr_i     = '0;
    memReqReady_i = 1'b0;
    memRdValid_i  = 1'b0;
    memRdLast_i   = 1'b0;
    memRdData_i   = '0;
    cfgWrite_i    = 1'b0;
    cfgAddr_i     = '0;
    cfgWdata_i    = '0;
    lineReqs      = '0;
    lastReqAddr   = '0;
    epoch         = 1;
    lcgState      = 12732;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    coldMiss();
    backToBackHits();
    twoWays();
    flushRefetch();
    disabledReads();
    counterReadback();
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire
